// File: dv/nr_timing_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nr_timing_tb
    import nr_frame_pkg::*, nr_width_pkg::*;
();

    // small test geometry giving a 1280 cycle frame
    localparam int SLOT          = 64;
    localparam int SYM_FIRST     = 8;
    localparam int SYM_NORMAL    = 4;
    localparam int SYM_EXT       = 5;
    localparam int SUBFRAME      = SLOT * slots_per_subframe;
    localparam int FRAME         = SUBFRAME * subframes_per_frame;
    // strobe held high for a few cycles but counted once
    localparam int PPS_HIGH      = 3;
    // drive step to first marker step
    localparam int RESTART_DELAY = 5;
    localparam int MARGIN        = 100;

    // each row gives strobe offset (-1 none, -2 random) and ext_cp level
    // and the number of cycles to observe
    // row 1 length leaves row 2 switching ext_cp partway into a slot
    localparam int NUM_ROWS = 5;
    localparam int ROW_STROBE [NUM_ROWS]  = '{-1, 10, -1, -2, -1};
    localparam int ROW_EXT [NUM_ROWS]     = '{0, 0, 1, 1, 0};
    localparam int ROW_OBSERVE [NUM_ROWS] = '{40, 2600, 500, 1500, 300};

    logic clk;
    logic rst;
    logic pps;
    logic ext_cp;

    logic                         frm_mrkr;
    logic [frame_sample_w-1:0]    frm_sample_cnt;
    logic                         sub_frame_mrkr;
    logic [subframe_sample_w-1:0] sub_frame_sample_cnt;
    logic [subframe_idx_w-1:0]    sub_frame_cnt;
    logic                         slot_mrkr;
    logic [slot_sample_w-1:0]     slot_sample_cnt;
    logic [slot_idx_w-1:0]        slot_cnt;
    logic                         sym_mrkr;
    logic [sym_sample_w-1:0]      sym_sample_cnt;
    logic [sym_idx_w-1:0]         sym_cnt;
    logic                         locked;

    // reference model state tracks the position the outputs show
    bit m_locked;
    bit m_ext;
    int m_pos;
    int m_sym_idx;
    int m_sym_sample;
    int restart_cnt;
    bit pps_prev_drv;

    int err_count;
    int seed;
    int cycles = 0;
    int limit = 0;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    nr_timing_top #(
        .SLOT_SAMPLES (SLOT),
        .SYM_FIRST    (SYM_FIRST),
        .SYM_NORMAL   (SYM_NORMAL),
        .SYM_EXT      (SYM_EXT)
    ) dut (
        .clk                  (clk),
        .rst                  (rst),
        .pps                  (pps),
        .ext_cp               (ext_cp),
        .frm_mrkr             (frm_mrkr),
        .frm_sample_cnt       (frm_sample_cnt),
        .sub_frame_mrkr       (sub_frame_mrkr),
        .sub_frame_sample_cnt (sub_frame_sample_cnt),
        .sub_frame_cnt        (sub_frame_cnt),
        .slot_mrkr            (slot_mrkr),
        .slot_sample_cnt      (slot_sample_cnt),
        .slot_cnt             (slot_cnt),
        .sym_mrkr             (sym_mrkr),
        .sym_sample_cnt       (sym_sample_cnt),
        .sym_cnt              (sym_cnt),
        .locked               (locked)
    );

    task automatic check_field(input string name, input int got, input int exp);
        if (got != exp) begin
            err_count = err_count + 1;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at first wrong value");
        end
    endtask

    // slot offset where symbol idx begins
    function automatic int sym_start_at(input int idx, input bit ext);
        if (ext) begin
            return idx * SYM_EXT;
        end else if (idx == 0) begin
            return 0;
        end
        // longer first symbol then equal ones
        return SYM_FIRST + (idx - 1) * SYM_NORMAL;
    endfunction

    // advance model by one cycle while ext_cp still holds the last driven level
    task automatic advance_model();
        bit restart;
        int ss;
        int n_syms;
        restart = 1'b0;
        if (restart_cnt > 0) begin
            restart_cnt = restart_cnt - 1;
            restart = (restart_cnt == 0);
        end
        if (restart) begin
            m_locked = 1'b1;
            m_pos = 0;
        end else if (m_locked) begin
            m_pos = (m_pos + 1) % FRAME;
        end
        if (m_locked) begin
            ss = m_pos % SLOT;
            // mode picked up at slot start only
            if (ss == 0) begin
                m_ext = ext_cp;
            end
            n_syms = m_ext ? syms_ext : syms_normal;
            m_sym_idx = 0;
            for (int i = 1; i < n_syms; i++) begin
                if (sym_start_at(i, m_ext) <= ss) begin
                    m_sym_idx = i;
                end
            end
            // leftover samples stay in the last symbol
            m_sym_sample = ss - sym_start_at(m_sym_idx, m_ext);
        end
    endtask

    task automatic compare_outputs();
        int pos;
        int sub_s;
        int slot_s;
        pos = m_locked ? m_pos : 0;
        sub_s = pos % SUBFRAME;
        slot_s = pos % SLOT;
        check_field("locked", locked, m_locked);
        check_field("frm_mrkr", frm_mrkr, m_locked && pos == 0);
        check_field("frm_sample_cnt", frm_sample_cnt, pos);
        check_field("sub_frame_mrkr", sub_frame_mrkr, m_locked && sub_s == 0);
        check_field("sub_frame_sample_cnt", sub_frame_sample_cnt, sub_s);
        check_field("sub_frame_cnt", sub_frame_cnt, pos / SUBFRAME);
        check_field("slot_mrkr", slot_mrkr, m_locked && slot_s == 0);
        check_field("slot_sample_cnt", slot_sample_cnt, slot_s);
        check_field("slot_cnt", slot_cnt, pos / SLOT);
        check_field("sym_mrkr", sym_mrkr, m_locked && m_sym_sample == 0);
        check_field("sym_sample_cnt", sym_sample_cnt, m_locked ? m_sym_sample : 0);
        check_field("sym_cnt", sym_cnt, m_locked ? m_sym_idx : 0);
    endtask

    // one cycle of model update, drive after the edge and check at the falling edge
    task automatic run_step(input bit pps_v, input bit ext_v);
        @(posedge clk);
        advance_model();
        #1;
        pps = pps_v;
        ext_cp = ext_v;
        // rising strobe restarts the model a fixed time later
        if (pps_v && !pps_prev_drv) begin
            restart_cnt = RESTART_DELAY;
        end
        pps_prev_drv = pps_v;
        @(negedge clk);
        compare_outputs();
    endtask

    initial begin
        int off;
        bit pps_v;
        pps = 1'b0;
        ext_cp = 1'b0;
        seed = 29;
        m_locked = 1'b0;
        m_ext = 1'b0;
        m_pos = 0;
        m_sym_idx = 0;
        m_sym_sample = 0;
        restart_cnt = 0;
        pps_prev_drv = 1'b0;
        err_count = 0;
        limit = MARGIN;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + ROW_OBSERVE[r];
        end
        wait (rst == 1'b0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            off = ROW_STROBE[r];
            // random realign somewhere mid frame
            if (off == -2) begin
                off = 200 + ($unsigned($random(seed)) % 800);
            end
            $display("row %0d: strobe at %0d, ext_cp %0d, %0d cycles",
                     r, off, ROW_EXT[r], ROW_OBSERVE[r]);
            for (int c = 0; c < ROW_OBSERVE[r]; c++) begin
                pps_v = (off >= 0) && (c >= off) && (c < off + PPS_HIGH);
                run_step(pps_v, ROW_EXT[r]);
            end
        end
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // hard stop if the table never finishes
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    // 8 ns period with the defaults
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module nr_timing_tb \
    -f sim.f -o nr_timing_sim \
    && ./obj_dir/nr_timing_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

// File: sim.f
src/nr_frame_pkg.sv
src/nr_width_pkg.sv
src/timing_ifs.sv
src/pps_sync.sv
src/frame_timer.sv
src/symbol_timer.sv
src/marker_out.sv
src/nr_timing_top.sv
dv/tb_clk_gen.sv
dv/nr_timing_tb.sv

// File: src/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer
    import nr_frame_pkg::*, nr_width_pkg::*;
#(
    parameter int SLOT_SAMPLES = slot_samples_default
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       align,
    frame_pos_if.src  pos
);

    localparam int SUBFRAME_SAMPLES = SLOT_SAMPLES * slots_per_subframe;
    localparam int FRAME_SAMPLES = SUBFRAME_SAMPLES * subframes_per_frame;
    localparam int SLOTS_PER_FRAME = slots_per_subframe * subframes_per_frame;

    // wrap values sized to each counter
    localparam logic [frame_sample_w-1:0] FRAME_LAST = frame_sample_w'(FRAME_SAMPLES - 1);
    localparam logic [subframe_sample_w-1:0] SUBFRAME_LAST =
        subframe_sample_w'(SUBFRAME_SAMPLES - 1);
    localparam logic [slot_sample_w-1:0] SLOT_LAST = slot_sample_w'(SLOT_SAMPLES - 1);
    localparam logic [slot_idx_w-1:0] SLOT_IDX_LAST = slot_idx_w'(SLOTS_PER_FRAME - 1);
    localparam logic [slot_idx_w-1:0] SLOT_IN_SUB_LAST = slot_idx_w'(slots_per_subframe - 1);
    localparam logic [subframe_idx_w-1:0] SUBFRAME_IDX_LAST =
        subframe_idx_w'(subframes_per_frame - 1);

    logic [frame_sample_w-1:0]    frame_sample;
    logic [subframe_sample_w-1:0] subframe_sample;
    logic [slot_sample_w-1:0]     slot_sample;
    logic [slot_idx_w-1:0]        slot_idx;
    // slot position inside the current subframe
    logic [slot_idx_w-1:0]        slot_in_sub;
    logic [subframe_idx_w-1:0]    subframe_idx;

    always_ff @(posedge clk) begin
        // align restarts the whole frame wherever we are
        if (rst || align) begin
            frame_sample    <= '0;
            subframe_sample <= '0;
            slot_sample     <= '0;
            slot_idx        <= '0;
            slot_in_sub     <= '0;
            subframe_idx    <= '0;
        end else begin
            frame_sample    <= (frame_sample == FRAME_LAST) ? '0 : frame_sample + 1'b1;
            subframe_sample <= (subframe_sample == SUBFRAME_LAST) ? '0
                             : subframe_sample + 1'b1;
            if (slot_sample == SLOT_LAST) begin
                slot_sample <= '0;
                slot_idx    <= (slot_idx == SLOT_IDX_LAST) ? '0 : slot_idx + 1'b1;
                // subframe index steps with the last slot of a subframe
                if (slot_in_sub == SLOT_IN_SUB_LAST) begin
                    slot_in_sub  <= '0;
                    subframe_idx <= (subframe_idx == SUBFRAME_IDX_LAST) ? '0
                                  : subframe_idx + 1'b1;
                end else begin
                    slot_in_sub <= slot_in_sub + 1'b1;
                end
            end else begin
                slot_sample <= slot_sample + 1'b1;
            end
        end
    end

    assign pos.frame_sample    = frame_sample;
    assign pos.subframe_sample = subframe_sample;
    assign pos.slot_sample     = slot_sample;
    assign pos.slot_idx        = slot_idx;
    assign pos.subframe_idx    = subframe_idx;

    // index and subframe counters kept in range across wraps
    a_slot_idx_range: assert property (
        @(posedge clk) disable iff (rst) slot_idx < SLOTS_PER_FRAME
    );
    a_subframe_sample_range: assert property (
        @(posedge clk) disable iff (rst) subframe_sample < SUBFRAME_SAMPLES
    );

endmodule

`default_nettype wire

// File: src/marker_out.sv
`timescale 1ns/1ps
`default_nettype none

module marker_out
    import nr_width_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          align,
    frame_pos_if.dst                     pos,
    symbol_pos_if.dst                    sym,
    output logic                         locked,
    output logic                         frm_mrkr,
    output logic [frame_sample_w-1:0]    frm_sample_cnt,
    output logic                         sub_frame_mrkr,
    output logic [subframe_sample_w-1:0] sub_frame_sample_cnt,
    output logic [subframe_idx_w-1:0]    sub_frame_cnt,
    output logic                         slot_mrkr,
    output logic [slot_sample_w-1:0]     slot_sample_cnt,
    output logic [slot_idx_w-1:0]        slot_cnt,
    output logic                         sym_mrkr,
    output logic [sym_sample_w-1:0]      sym_sample_cnt,
    output logic [sym_idx_w-1:0]         sym_cnt
);

    // armed on the first align as the counters restart
    logic armed;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed  <= 1'b0;
            locked <= 1'b0;
        end else begin
            if (align) begin
                armed <= 1'b1;
            end
            // lines up with the first marker
            locked <= armed;
        end
    end

    always_ff @(posedge clk) begin
        // quiet until aligned
        if (rst || !armed) begin
            frm_mrkr             <= 1'b0;
            frm_sample_cnt       <= '0;
            sub_frame_mrkr       <= 1'b0;
            sub_frame_sample_cnt <= '0;
            sub_frame_cnt        <= '0;
            slot_mrkr            <= 1'b0;
            slot_sample_cnt      <= '0;
            slot_cnt             <= '0;
            sym_mrkr             <= 1'b0;
            sym_sample_cnt       <= '0;
            sym_cnt              <= '0;
        end else begin
            // marker is the zero sample of each unit
            frm_mrkr             <= (pos.frame_sample == '0);
            frm_sample_cnt       <= pos.frame_sample;
            sub_frame_mrkr       <= (pos.subframe_sample == '0);
            sub_frame_sample_cnt <= pos.subframe_sample;
            sub_frame_cnt        <= pos.subframe_idx;
            slot_mrkr            <= (pos.slot_sample == '0);
            slot_sample_cnt      <= pos.slot_sample;
            slot_cnt             <= pos.slot_idx;
            sym_mrkr             <= sym.sym_start;
            sym_sample_cnt       <= sym.sym_sample;
            sym_cnt              <= sym.sym_idx;
        end
    end

    // frame start coincides with every lower boundary and symbol 0
    a_frame_nesting: assert property (
        @(posedge clk) disable iff (rst)
        frm_mrkr |-> (sub_frame_mrkr && slot_mrkr && sym_mrkr && sym_cnt == '0
                      && slot_cnt == '0 && sub_frame_cnt == '0)
    );

endmodule

`default_nettype wire

// File: src/nr_frame_pkg.sv
`default_nettype none

package nr_frame_pkg;

    // radio frame structure, 10 ms frame
    localparam int subframes_per_frame = 10;
    // 30 kHz subcarrier spacing, two slots per 1 ms subframe
    localparam int slots_per_subframe = 2;

    // 0.5 ms slot at 491.52 MHz sample rate
    localparam int slot_samples_default = 245760;

    // normal cp, first symbol carries the longer prefix
    localparam int sym_first_default = 17792;
    localparam int sym_normal_default = 17536;
    // extended cp, all symbols equal
    localparam int sym_ext_default = 20480;

    // symbols per slot for each cp mode
    localparam int syms_normal = 14;
    localparam int syms_ext = 12;

endpackage

`default_nettype wire

// File: src/nr_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module nr_timing_top
    import nr_frame_pkg::*, nr_width_pkg::*;
#(
    parameter int SLOT_SAMPLES = slot_samples_default,
    parameter int SYM_FIRST    = sym_first_default,
    parameter int SYM_NORMAL   = sym_normal_default,
    parameter int SYM_EXT      = sym_ext_default
) (
    input  wire                          clk,
    input  wire                          rst,
    // external one pulse per second
    input  wire                          pps,
    // level, 1 selects extended cp
    input  wire                          ext_cp,
    output logic                         frm_mrkr,
    output logic [frame_sample_w-1:0]    frm_sample_cnt,
    output logic                         sub_frame_mrkr,
    output logic [subframe_sample_w-1:0] sub_frame_sample_cnt,
    output logic [subframe_idx_w-1:0]    sub_frame_cnt,
    output logic                         slot_mrkr,
    output logic [slot_sample_w-1:0]     slot_sample_cnt,
    output logic [slot_idx_w-1:0]        slot_cnt,
    output logic                         sym_mrkr,
    output logic [sym_sample_w-1:0]      sym_sample_cnt,
    output logic [sym_idx_w-1:0]         sym_cnt,
    output logic                         locked
);

    logic align;

    frame_pos_if  pos_if ();
    symbol_pos_if sym_if ();

    // strobe in, single cycle align out
    pps_sync u_pps_sync (
        .clk   (clk),
        .rst   (rst),
        .pps   (pps),
        .align (align)
    );

    frame_timer #(
        .SLOT_SAMPLES (SLOT_SAMPLES)
    ) u_frame_timer (
        .clk   (clk),
        .rst   (rst),
        .align (align),
        .pos   (pos_if.src)
    );

    symbol_timer #(
        .SLOT_SAMPLES (SLOT_SAMPLES),
        .SYM_FIRST    (SYM_FIRST),
        .SYM_NORMAL   (SYM_NORMAL),
        .SYM_EXT      (SYM_EXT)
    ) u_symbol_timer (
        .clk    (clk),
        .rst    (rst),
        .ext_cp (ext_cp),
        .pos    (pos_if.dst),
        .sym    (sym_if.src)
    );

    // registered outputs, one cycle behind the position
    marker_out u_marker_out (
        .clk                  (clk),
        .rst                  (rst),
        .align                (align),
        .pos                  (pos_if.dst),
        .sym                  (sym_if.dst),
        .locked               (locked),
        .frm_mrkr             (frm_mrkr),
        .frm_sample_cnt       (frm_sample_cnt),
        .sub_frame_mrkr       (sub_frame_mrkr),
        .sub_frame_sample_cnt (sub_frame_sample_cnt),
        .sub_frame_cnt        (sub_frame_cnt),
        .slot_mrkr            (slot_mrkr),
        .slot_sample_cnt      (slot_sample_cnt),
        .slot_cnt             (slot_cnt),
        .sym_mrkr             (sym_mrkr),
        .sym_sample_cnt       (sym_sample_cnt),
        .sym_cnt              (sym_cnt)
    );

endmodule

`default_nettype wire

// File: src/nr_width_pkg.sv
`default_nettype none

package nr_width_pkg;

    // sample position within the 10 ms frame
    localparam int frame_sample_w = 23;
    // sample position within a 1 ms subframe
    localparam int subframe_sample_w = 19;
    // sample position within a 0.5 ms slot
    localparam int slot_sample_w = 18;

    // subframe index 0..9
    localparam int subframe_idx_w = 4;
    // slot index within the frame, 0..19
    localparam int slot_idx_w = 5;

    // symbol index within the slot, 0..13
    localparam int sym_idx_w = 4;
    // sample position within one symbol
    localparam int sym_sample_w = 16;

endpackage

`default_nettype wire

// File: src/pps_sync.sv
`timescale 1ns/1ps
`default_nettype none

module pps_sync (
    input  wire  clk,
    input  wire  rst,
    input  wire  pps,
    output logic align
);

    // two stage synchroniser for the async strobe
    logic pps_meta;
    logic pps_sync_q;
    // previous synchronised level for edge detect
    logic pps_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            pps_meta   <= 1'b0;
            pps_sync_q <= 1'b0;
            pps_prev   <= 1'b0;
            align      <= 1'b0;
        end else begin
            pps_meta   <= pps;
            pps_sync_q <= pps_meta;
            pps_prev   <= pps_sync_q;
            // rising edge only, registered so align is one clean cycle
            align      <= pps_sync_q & ~pps_prev;
        end
    end

    // a held strobe must not retrigger
    a_align_single: assert property (
        @(posedge clk) disable iff (rst) align |=> !align
    );

endmodule

`default_nettype wire

// File: src/symbol_timer.sv
`timescale 1ns/1ps
`default_nettype none

module symbol_timer
    import nr_frame_pkg::*, nr_width_pkg::*;
#(
    parameter int SLOT_SAMPLES = slot_samples_default,
    parameter int SYM_FIRST    = sym_first_default,
    parameter int SYM_NORMAL   = sym_normal_default,
    parameter int SYM_EXT      = sym_ext_default
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       ext_cp,
    frame_pos_if.dst  pos,
    symbol_pos_if.src sym
);

    localparam logic [slot_sample_w-1:0] FIRST_LEN = slot_sample_w'(SYM_FIRST);
    localparam logic [slot_sample_w-1:0] NORM_LEN = slot_sample_w'(SYM_NORMAL);
    localparam logic [slot_sample_w-1:0] EXT_LEN = slot_sample_w'(SYM_EXT);
    localparam logic [sym_idx_w-1:0] LAST_NORM = sym_idx_w'(syms_normal - 1);
    localparam logic [sym_idx_w-1:0] LAST_EXT = sym_idx_w'(syms_ext - 1);

    // symbol grid must fit inside one slot
    if (SYM_FIRST + (syms_normal - 1) * SYM_NORMAL > SLOT_SAMPLES) begin : g_bad_normal
        $error("normal cp symbols overrun the slot");
    end
    if (syms_ext * SYM_EXT > SLOT_SAMPLES) begin : g_bad_ext
        $error("extended cp symbols overrun the slot");
    end

    // cp mode latched at slot start
    logic                     ext_q;
    // slot sample where the next symbol begins
    logic [slot_sample_w-1:0] bound_q;
    logic [sym_idx_w-1:0]     sym_idx_q;
    logic [sym_sample_w-1:0]  sym_sample_q;

    logic                     slot_start;
    logic                     mode_now;
    logic                     hit;
    logic [sym_idx_w-1:0]     last_idx;
    logic                     sym_start_c;
    logic [sym_idx_w-1:0]     sym_idx_c;
    logic [sym_sample_w-1:0]  sym_sample_c;

    always_comb begin
        slot_start = (pos.slot_sample == '0);
        // new mode applies from this slot start onward
        mode_now = slot_start ? ext_cp : ext_q;
        last_idx = ext_q ? LAST_EXT : LAST_NORM;
        // leftover samples after the last boundary stay in the last symbol
        hit = !slot_start && (pos.slot_sample == bound_q) && (sym_idx_q < last_idx);
        sym_start_c = slot_start || hit;
        if (slot_start) begin
            sym_idx_c = '0;
        end else if (hit) begin
            sym_idx_c = sym_idx_q + 1'b1;
        end else begin
            sym_idx_c = sym_idx_q;
        end
        sym_sample_c = sym_start_c ? '0 : sym_sample_q + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ext_q        <= 1'b0;
            bound_q      <= '0;
            sym_idx_q    <= '0;
            sym_sample_q <= '0;
        end else begin
            ext_q        <= mode_now;
            sym_idx_q    <= sym_idx_c;
            sym_sample_q <= sym_sample_c;
            if (slot_start) begin
                bound_q <= ext_cp ? EXT_LEN : FIRST_LEN;
            end else if (hit) begin
                bound_q <= bound_q + (ext_q ? EXT_LEN : NORM_LEN);
            end
        end
    end

    // zero latency, straight onto the interface
    assign sym.sym_start  = sym_start_c;
    assign sym.sym_idx    = sym_idx_c;
    assign sym.sym_sample = sym_sample_c;

    a_sym_idx_limit: assert property (
        @(posedge clk) disable iff (rst)
        sym_idx_c < (mode_now ? syms_ext : syms_normal)
    );

endmodule

`default_nettype wire

// File: src/timing_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// frame position, one sample per clock
interface frame_pos_if
    import nr_width_pkg::*;
();
    logic [frame_sample_w-1:0]    frame_sample;
    logic [subframe_sample_w-1:0] subframe_sample;
    logic [slot_sample_w-1:0]     slot_sample;
    logic [subframe_idx_w-1:0]    subframe_idx;
    // slot index counted over the whole frame
    logic [slot_idx_w-1:0]        slot_idx;

    modport src (
        output frame_sample, subframe_sample, slot_sample, subframe_idx, slot_idx
    );
    modport dst (
        input frame_sample, subframe_sample, slot_sample, subframe_idx, slot_idx
    );
endinterface

// symbol position, same cycle as frame_pos_if
interface symbol_pos_if
    import nr_width_pkg::*;
();
    // high on first sample of each symbol
    logic                    sym_start;
    logic [sym_idx_w-1:0]    sym_idx;
    logic [sym_sample_w-1:0] sym_sample;

    modport src (output sym_start, sym_idx, sym_sample);
    modport dst (input sym_start, sym_idx, sym_sample);
endinterface

`default_nettype wire
